// File: hwlp_sub.f
hdl/hwlp_pkg.sv
hdl/hwlp_if.sv
hdl/hwlp_setup_decoder.sv
hdl/hwlp_regs.sv
hdl/hwlp_controller.sv
hdl/hwlp_pc_select.sv
hdl/hwlp_top.sv
verif/tb_clkgen.sv
verif/hwlp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module hwlp_tb -f hwlp_sub.f -o hwlp_sim \
  && { ./obj_dir/hwlp_sim > sim.log 2>&1; grep -q "^TB PASSED$" sim.log; } \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: verif/hwlp_tb.sv
`timescale 1ns/1ps

module hwlp_tb;

  localparam int unsigned N_LOOPS   = 2;
  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam int          ADDR_W    = 7;
  localparam int          MEM_WORDS = 1 << ADDR_W;
  // valid words executed by each test, reset cycles on top
  localparam int STREAM_WORDS = 12;
  localparam int SETUPI_WORDS = 7;
  localparam int SINGLE_WORDS = 27;
  localparam int NESTED_WORDS = 21;
  localparam int COUNT2_WORDS = 6;
  localparam int RESET_CYCLES = 8;
  localparam int TIMEOUT_CYCLES = 2 * (STREAM_WORDS + SETUPI_WORDS + SINGLE_WORDS
                                       + NESTED_WORDS + COUNT2_WORDS + RESET_CYCLES);

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr_word;
  logic [31:0] pc;
  logic        hwlp_jump;
  logic [31:0] targ_addr;

  // program memory, one word per address from BOOT_ADDR
  logic [31:0] prog [MEM_WORDS];
  int          seed;
  int          errors;
  int          checks;
  int          cycles;
  // jumps seen by the current run, and those landing on watch_addr
  int          jumps;
  int          watch_hits;
  logic [31:0] watch_addr;

  // reference loop state, stepped with the same valid edges
  logic [31:0] ref_pc;
  logic [31:0] ref_start [N_LOOPS];
  logic [31:0] ref_end   [N_LOOPS];
  logic [31:0] ref_cnt   [N_LOOPS];
  logic        ref_dec   [N_LOOPS];

  tb_clkgen #(.RESET_CYCLES(RESET_CYCLES)) i_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  hwlp_top #(
    .N_LOOPS   (N_LOOPS),
    .BOOT_ADDR (BOOT_ADDR)
  ) i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .instr_valid_i    (instr_valid),
    .instr_i          (instr_word),
    .pc_o             (pc),
    .hwlp_jump_o      (hwlp_jump),
    .hwlp_targ_addr_o (targ_addr)
  );

  ////////////////////////////////////////////////////////////
  // word encoding and program memory
  ////////////////////////////////////////////////////////////

  // count | body_len | funct | idx | 4 filler bits | opcode
  function automatic logic [31:0] encode_setupi(input logic idx, input logic [11:0] count,
                                                input logic [4:0] len);
    return {count, len, hwlp_pkg::SETUPI, idx, 4'b0000, hwlp_pkg::HWLP_OPCODE};
  endfunction

  function automatic logic [31:0] encode_single(input hwlp_pkg::hwlp_funct_e funct,
                                                input logic idx, input logic [11:0] imm);
    return {imm, 5'd0, funct, idx, 4'b0000, hwlp_pkg::HWLP_OPCODE};
  endfunction

  function automatic logic [ADDR_W-1:0] word_idx(input logic [31:0] addr);
    logic [31:0] offset;
    offset = (addr - BOOT_ADDR) >> 2;
    return offset[ADDR_W-1:0];
  endfunction

  // body of n passes takes n-1 jumps, a count below two none
  function automatic int expected_jumps(input int n);
    return (n > 1) ? n - 1 : 0;
  endfunction

  task automatic place_word(input logic [31:0] addr, input logic [31:0] word);
    prog[word_idx(addr)] = word;
  endtask

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog[i]      = $random(seed);
      // op-imm opcode, never taken for a loop setup
      prog[i][6:0] = 7'h13;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // register writes of one consumed word at address addr
  task automatic apply_setup_word(input logic [31:0] word, input logic [31:0] addr);
    logic        idx;
    logic [11:0] imm;
    idx = word[11];
    imm = word[31:20];
    if (word[6:0] == hwlp_pkg::HWLP_OPCODE) begin
      case (word[14:12])
        hwlp_pkg::SETUPI: begin
          ref_start[idx] = addr + 32'd4;
          ref_end[idx]   = addr + 32'd4 + {25'd0, word[19:15], 2'b00};
          ref_cnt[idx]   = {20'd0, imm};
        end
        hwlp_pkg::STARTI: ref_start[idx] = addr + {18'd0, imm, 2'b00};
        hwlp_pkg::ENDI:   ref_end[idx]   = addr + {18'd0, imm, 2'b00};
        hwlp_pkg::COUNTI: ref_cnt[idx]   = {20'd0, imm};
        default: ;
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_addr(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic check_jump(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected jump %b, actual jump %b", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("Fail %s: expected %0d jumps, actual %0d jumps", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // one clock cycle with model and checks
  ////////////////////////////////////////////////////////////

  task automatic run_cycle(input string name, input logic valid);
    logic [31:0] word;
    logic [31:0] next_pc;
    logic        exp_jump;
    int          win;
    word     = prog[word_idx(ref_pc)];
    exp_jump = 1'b0;
    win      = 0;
    @(posedge clk);
    instr_valid <= valid;
    instr_word  <= word;
    @(negedge clk);
    // lowest loop ending after this word whose count,
    // less the pending decrement, is still two or more
    for (int i = N_LOOPS - 1; i >= 0; i--) begin
      if (valid && (ref_pc + 32'd4 == ref_end[i])
          && (ref_cnt[i] >= 32'd2 + {31'd0, ref_dec[i]})) begin
        exp_jump = 1'b1;
        win      = i;
      end
    end
    check_addr(name, ref_pc, pc);
    check_jump(name, exp_jump, hwlp_jump);
    if (exp_jump) begin
      check_addr({name, "_target"}, ref_start[win], targ_addr);
    end
    if (hwlp_jump) begin
      jumps++;
      if (targ_addr == watch_addr) begin
        watch_hits++;
      end
    end
    // effect of the coming edge, a write wins over the decrement
    if (valid) begin
      next_pc = exp_jump ? ref_start[win] : ref_pc + 32'd4;
      for (int i = 0; i < N_LOOPS; i++) begin
        if (ref_dec[i]) begin
          ref_cnt[i] = ref_cnt[i] - 32'd1;
        end
        ref_dec[i] = exp_jump && (win == i);
      end
      apply_setup_word(word, ref_pc);
      ref_pc = next_pc;
    end
  endtask

  // gap n drops every n-th cycle, one idle cycle shows the exit pc
  task automatic run_to(input string name, input logic [31:0] stop_pc, input int gap,
                        input int exp_jumps);
    int k;
    k          = 0;
    jumps      = 0;
    watch_hits = 0;
    while (ref_pc != stop_pc) begin
      run_cycle(name, !((gap != 0) && ((k % gap) == gap - 1)));
      k++;
    end
    run_cycle(name, 1'b0);
    check_addr({name, "_fallthrough"}, stop_pc, pc);
    check_count(name, exp_jumps, jumps);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_hold();
    check_addr("reset", BOOT_ADDR, pc);
    check_jump("reset", 1'b0, hwlp_jump);
    repeat (5) run_cycle("reset_hold", 1'b0);
    check_addr("reset_hold_fallthrough", BOOT_ADDR, pc);
  endtask

  task automatic test_plain_stream();
    run_to("stream", ref_pc + 32'(4 * STREAM_WORDS), 4, 0);
  endtask

  task automatic test_setupi_loop();
    logic [31:0] base;
    base = ref_pc;
    place_word(base, encode_setupi(1'b0, 12'd3, 5'd2));
    run_to("setupi_l0", base + 32'd12, 0, expected_jumps(3));
  endtask

  // loop 1 from STARTI, ENDI and COUNTI, body of three words
  task automatic test_single_writes();
    int          counts [3] = '{4, 1, 0};
    logic [31:0] base;
    for (int t = 0; t < 3; t++) begin
      base = ref_pc;
      place_word(base, encode_single(hwlp_pkg::STARTI, 1'b1, 12'd3));
      place_word(base + 32'd4, encode_single(hwlp_pkg::ENDI, 1'b1, 12'd5));
      place_word(base + 32'd8, encode_single(hwlp_pkg::COUNTI, 1'b1, 12'(counts[t])));
      run_to($sformatf("single_l1_cnt%0d", counts[t]), base + 32'd24, 0,
             expected_jumps(counts[t]));
    end
  endtask

  // outer loop 1 holds the inner setup, both share one end address
  task automatic test_nested_loops();
    logic [31:0] base;
    base = ref_pc;
    place_word(base, encode_setupi(1'b1, 12'd2, 5'd4));
    place_word(base + 32'd4, encode_setupi(1'b0, 12'd3, 5'd3));
    watch_addr = base + 32'd8;
    run_to("nested", base + 32'd20, 0, 2 * expected_jumps(3) + expected_jumps(2));
    check_count("nested_inner", 2 * expected_jumps(3), watch_hits);
  endtask

  // one-word body, the second pass sees the decrement in flight
  task automatic test_count_two();
    logic [31:0] base;
    base = ref_pc;
    place_word(base, encode_setupi(1'b0, 12'd2, 5'd1));
    run_to("count2", base + 32'd8, 0, expected_jumps(2));
    base = ref_pc;
    place_word(base, encode_setupi(1'b0, 12'd2, 5'd1));
    run_to("count2_gaps", base + 32'd8, 2, expected_jumps(2));
  endtask

  initial begin
    instr_valid = 1'b0;
    instr_word  = '0;
    seed        = 32'hc13c;
    errors      = 0;
    checks      = 0;
    watch_addr  = '0;
    ref_pc      = BOOT_ADDR;
    for (int i = 0; i < N_LOOPS; i++) begin
      ref_start[i] = '0;
      ref_end[i]   = '0;
      ref_cnt[i]   = '0;
      ref_dec[i]   = 1'b0;
    end
    fill_memory();
    wait (rst_n === 1'b1);
    @(negedge clk);
    test_reset_hold();
    test_plain_stream();
    test_setupi_loop();
    test_single_writes();
    test_nested_loops();
    test_count_two();
    $display("hwlp_tb: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // run limit from the test lengths
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  always #2 clk_o = ~clk_o;

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    // release on a rising edge, like any other driven input
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: hdl/hwlp_top.sv
`timescale 1ns/1ps

module hwlp_top #(
  parameter int unsigned N_LOOPS   = 2,
  parameter logic [31:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  output logic [31:0] pc_o,
  output logic        hwlp_jump_o,
  output logic [31:0] hwlp_targ_addr_o
);

  hwlp_pkg::hwlp_instr_u  instr_u;
  hwlp_pkg::hwlp_wr_cmd_t wr_cmd;

  // raw word seen through the loop setup views
  assign instr_u = hwlp_pkg::hwlp_instr_u'(instr_i);

  hwlp_if #(.N_LOOPS(N_LOOPS)) hw_if ();

  ////////////////////////////////////////////////////////////
  // decode, loop registers, controller, pc
  ////////////////////////////////////////////////////////////

  hwlp_setup_decoder i_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_u),
    .pc_i          (pc_o),
    .wr_cmd_o      (wr_cmd)
  );

  hwlp_regs #(.N_LOOPS(N_LOOPS)) i_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .wr_cmd_i      (wr_cmd),
    .hw            (hw_if.regs_mp)
  );

  hwlp_controller #(.N_LOOPS(N_LOOPS)) i_controller (
    .clk              (clk),
    .rst_n            (rst_n),
    .instr_valid_i    (instr_valid_i),
    .pc_i             (pc_o),
    .hw               (hw_if.ctrl_mp),
    .hwlp_jump_o      (hwlp_jump_o),
    .hwlp_targ_addr_o (hwlp_targ_addr_o)
  );

  // jump and target go straight back into next-pc select
  hwlp_pc_select #(
    .N_LOOPS   (N_LOOPS),
    .BOOT_ADDR (BOOT_ADDR)
  ) i_pc_select (
    .clk              (clk),
    .rst_n            (rst_n),
    .instr_valid_i    (instr_valid_i),
    .hwlp_jump_i      (hwlp_jump_o),
    .hwlp_targ_addr_i (hwlp_targ_addr_o),
    .hw               (hw_if.pc_mp),
    .pc_o             (pc_o)
  );

endmodule

// File: hdl/hwlp_pc_select.sv
`timescale 1ns/1ps

module hwlp_pc_select #(
  parameter int unsigned N_LOOPS   = 2,
  parameter logic [31:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic        hwlp_jump_i,
  input  logic [31:0] hwlp_targ_addr_i,
  hwlp_if.pc_mp       hw,
  output logic [31:0] pc_o
);

  logic [31:0]        pc_q;
  logic [31:0]        pc_n;
  logic [N_LOOPS-1:0] dec_q;

  // loop target on a jump, sequential fetch otherwise
  assign pc_n = hwlp_jump_i ? hwlp_targ_addr_i : pc_q + 32'd4;

  ////////////////////////////////////////////////////////////
  // pc and in-flight decrement
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q  <= BOOT_ADDR;
      dec_q <= '0;
    end else if (instr_valid_i) begin
      // nothing moves while the stream stalls
      pc_q  <= pc_n;
      // held until the next valid edge, where the
      // register file consumes it
      dec_q <= hw.dec_cnt_jump;
    end
  end

  assign pc_o          = pc_q;
  assign hw.dec_cnt_id = dec_q;

  // targets come from decoded setup words, a bad offset
  // would show up here first
  pc_aligned_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    pc_q[1:0] == 2'b00
  ) else $error("hwlp: pc 0x%08h not word aligned", pc_q);

endmodule

// File: hdl/hwlp_controller.sv
`timescale 1ns/1ps

module hwlp_controller #(
  parameter int unsigned N_LOOPS = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic [31:0] pc_i,
  hwlp_if.ctrl_mp     hw,
  output logic        hwlp_jump_o,
  output logic [31:0] hwlp_targ_addr_o
);

  logic [31:0]        pc_next;
  // word at pc_i is the last body word of loop i
  logic [N_LOOPS-1:0] at_end;
  // counter still allows another pass
  logic [N_LOOPS-1:0] cnt_ok;
  logic [N_LOOPS-1:0] hit;
  logic               found;

  assign pc_next = pc_i + 32'd4;

  ////////////////////////////////////////////////////////////
  // end address compare
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N_LOOPS; i++) begin
      at_end[i] = (pc_next == hw.end_addr[i]);

      // three or more, always room for one more jump
      // exactly two, only if no decrement is still pending
      if (hw.counter[i][31:2] != 30'd0) begin
        cnt_ok[i] = 1'b1;
      end else begin
        case (hw.counter[i][1:0])
          2'b11:   cnt_ok[i] = 1'b1;
          2'b10:   cnt_ok[i] = ~hw.dec_cnt_id[i];
          default: cnt_ok[i] = 1'b0;
        endcase
      end

      hit[i] = instr_valid_i && at_end[i] && cnt_ok[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // target select, lowest index first
  ////////////////////////////////////////////////////////////

  always_comb begin
    found            = 1'b0;
    hwlp_targ_addr_o = '0;
    hw.dec_cnt_jump  = '0;

    for (int i = 0; i < N_LOOPS; i++) begin
      if (hit[i] && !found) begin
        found              = 1'b1;
        hwlp_targ_addr_o   = hw.start_addr[i];
        hw.dec_cnt_jump[i] = 1'b1;
      end
    end
  end

  assign hwlp_jump_o = found;

  // only one loop may be charged per jump, even with nested
  // loops sharing an end address
  dec_onehot_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(hw.dec_cnt_jump)
  ) else $error("hwlp: more than one loop decremented");

  // jump must line up with a consumed word, else pc and
  // counter would drift apart
  jump_valid_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    hwlp_jump_o |-> instr_valid_i
  ) else $error("hwlp: jump without a valid instruction");

endmodule

// File: hdl/hwlp_regs.sv
`timescale 1ns/1ps

module hwlp_regs #(
  parameter int unsigned N_LOOPS = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid_i,
  input  hwlp_pkg::hwlp_wr_cmd_t wr_cmd_i,
  hwlp_if.regs_mp                hw
);

  logic [N_LOOPS-1:0][31:0] start_q;
  logic [N_LOOPS-1:0][31:0] end_q;
  logic [N_LOOPS-1:0][31:0] cnt_q;
  // per-loop write select
  logic [N_LOOPS-1:0]       wr_sel;

  always_comb begin
    for (int i = 0; i < N_LOOPS; i++) begin
      wr_sel[i] = instr_valid_i && wr_cmd_i.valid && (32'(wr_cmd_i.idx) == i);
    end
  end

  ////////////////////////////////////////////////////////////
  // start and end addresses
  ////////////////////////////////////////////////////////////

  // loop bounds, written by setup words only
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_LOOPS; i++) begin
      if (wr_sel[i] && wr_cmd_i.we_start) begin
        start_q[i] <= wr_cmd_i.start;
      end
      if (wr_sel[i] && wr_cmd_i.we_end) begin
        end_q[i] <= wr_cmd_i.end_addr;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (instr_valid_i) begin
      for (int i = 0; i < N_LOOPS; i++) begin
        // a new count overrides the pending decrement
        if (wr_sel[i] && wr_cmd_i.we_cnt) begin
          cnt_q[i] <= wr_cmd_i.count;
        end else if (hw.dec_cnt_id[i]) begin
          cnt_q[i] <= cnt_q[i] - 32'd1;
        end
      end
    end
  end

  assign hw.start_addr = start_q;
  assign hw.end_addr   = end_q;
  assign hw.counter    = cnt_q;

  // the controller only jumps on a counter of two or more,
  // so the late decrement must always find something left
  for (genvar g = 0; g < N_LOOPS; g++) begin : g_chk
    cnt_no_underflow_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      (instr_valid_i && hw.dec_cnt_id[g] && !(wr_sel[g] && wr_cmd_i.we_cnt))
        |-> (cnt_q[g] != 32'd0)
    ) else $error("hwlp: loop %0d counter decremented from zero", g);
  end

endmodule

// File: hdl/hwlp_setup_decoder.sv
`timescale 1ns/1ps

module hwlp_setup_decoder (
  input  logic                   instr_valid_i,
  input  hwlp_pkg::hwlp_instr_u  instr_i,
  input  logic [31:0]            pc_i,
  output hwlp_pkg::hwlp_wr_cmd_t wr_cmd_o
);

  logic        is_hwlp;
  logic [31:0] pc_next;
  logic [31:0] body_bytes;
  logic [31:0] imm_bytes;

  // opcode sits at the same bits in every view
  assign is_hwlp    = (instr_i.setupi.opcode == hwlp_pkg::HWLP_OPCODE);
  assign pc_next    = pc_i + 32'd4;

  // body length and offsets are counted in words
  assign body_bytes = {25'd0, instr_i.setupi.body_len, 2'b00};
  assign imm_bytes  = {18'd0, instr_i.single.imm, 2'b00};

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    wr_cmd_o     = '0;
    wr_cmd_o.idx = instr_i.setupi.idx;

    if (instr_valid_i && is_hwlp) begin
      case (instr_i.setupi.funct)
        hwlp_pkg::SETUPI: begin
          // body is the k words after the setup word
          wr_cmd_o.valid    = 1'b1;
          wr_cmd_o.we_start = 1'b1;
          wr_cmd_o.we_end   = 1'b1;
          wr_cmd_o.we_cnt   = 1'b1;
          wr_cmd_o.start    = pc_next;
          wr_cmd_o.end_addr = pc_next + body_bytes;
          wr_cmd_o.count    = {20'd0, instr_i.setupi.count};
        end
        hwlp_pkg::STARTI: begin
          wr_cmd_o.valid    = 1'b1;
          wr_cmd_o.we_start = 1'b1;
          wr_cmd_o.start    = pc_i + imm_bytes;
        end
        hwlp_pkg::ENDI: begin
          // end is the address after the last body word
          wr_cmd_o.valid    = 1'b1;
          wr_cmd_o.we_end   = 1'b1;
          wr_cmd_o.end_addr = pc_i + imm_bytes;
        end
        hwlp_pkg::COUNTI: begin
          wr_cmd_o.valid    = 1'b1;
          wr_cmd_o.we_cnt   = 1'b1;
          wr_cmd_o.count    = {20'd0, instr_i.single.imm};
        end
        default: begin
          // unknown funct, no write at all
          wr_cmd_o.valid    = 1'b0;
        end
      endcase
    end
  end

  // an empty body would put the loop end right after the setup word,
  // so the loop could never be seen before its end is reached
  bodylen_nz_a : assert final (!(wr_cmd_o.valid && wr_cmd_o.we_start && wr_cmd_o.we_end
                                 && (instr_i.setupi.body_len == 5'd0)))
    else $error("hwlp: loop setup with zero body length");

endmodule

// File: hdl/hwlp_if.sv
`timescale 1ns/1ps

interface hwlp_if #(
  parameter int unsigned N_LOOPS = 2
);

  // loop register values, one word per loop
  logic [N_LOOPS-1:0][31:0] start_addr;
  logic [N_LOOPS-1:0][31:0] end_addr;
  logic [N_LOOPS-1:0][31:0] counter;

  // decrement raised by the controller in the jump cycle
  logic [N_LOOPS-1:0]       dec_cnt_jump;
  // same decrement one valid edge later, still in flight
  logic [N_LOOPS-1:0]       dec_cnt_id;

  // register file side
  modport regs_mp (
    output start_addr,
    output end_addr,
    output counter,
    input  dec_cnt_id
  );

  // end address compare and target select
  modport ctrl_mp (
    input  start_addr,
    input  end_addr,
    input  counter,
    input  dec_cnt_id,
    output dec_cnt_jump
  );

  // pc stage holds the in-flight decrement
  modport pc_mp (
    input  dec_cnt_jump,
    output dec_cnt_id
  );

endinterface

// File: hdl/hwlp_pkg.sv
package hwlp_pkg;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // custom-1 major opcode, reserved here for loop setup words
  localparam logic [6:0] HWLP_OPCODE = 7'b0101011;

  // funct picks which view of the word applies
  typedef enum logic [2:0] {
    SETUPI = 3'b000,
    STARTI = 3'b001,
    ENDI   = 3'b010,
    COUNTI = 3'b011
  } hwlp_funct_e;

  ////////////////////////////////////////////////////////////
  // instruction views
  ////////////////////////////////////////////////////////////

  // full setup, body starts right after the setup word
  typedef struct packed {
    logic [11:0] count;
    logic [4:0]  body_len;
    hwlp_funct_e funct;
    logic        idx;
    logic [3:0]  rsvd;
    logic [6:0]  opcode;
  } hwlp_setupi_t;

  // single register write, imm is an unsigned word offset or a count
  // funct and idx sit at the same bits as in the setup view
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rsvd_hi;
    hwlp_funct_e funct;
    logic        idx;
    logic [3:0]  rsvd_lo;
    logic [6:0]  opcode;
  } hwlp_single_t;

  typedef union packed {
    logic [31:0]  raw;
    hwlp_setupi_t setupi;
    hwlp_single_t single;
  } hwlp_instr_u;

  // decoded write toward the loop register file
  typedef struct packed {
    logic        valid;
    logic        idx;
    logic        we_start;
    logic        we_end;
    logic        we_cnt;
    logic [31:0] start;
    logic [31:0] end_addr;
    logic [31:0] count;
  } hwlp_wr_cmd_t;

endpackage
